//--- hdl/hash_table_macros.svh
`ifndef HASH_TABLE_MACROS_SVH
`define HASH_TABLE_MACROS_SVH

`define HT_KEY_WIDTH  16
`define HT_DATA_WIDTH 32
`define HT_NUM_TABLES 3
`define HT_ADR_WIDTH  6

// H3 masks, one 16-bit row per address bit, row 0 in the low bits
// rows keep bit 15 equal to bit 0 and bit 14 equal to bit 1
// so keys that differ by 16'h8001 or 16'h4002 share a bucket in every table
`define HT_Q_TABLE_0 {16'h1F38, 16'hD60B, 16'h27D4, \
                      16'h4B1E, 16'h8E59, 16'hC3A7}

`define HT_Q_TABLE_1 {16'h9B2D, 16'h6876, 16'hE1D7, \
                      16'h3E6C, 16'hB4C5, 16'h5A92}

`define HT_Q_TABLE_2 {16'h2A7C, 16'h96B5, 16'h0D98, \
                      16'hF05B, 16'hA3E1, 16'h7C4A}

`endif

//--- hdl/hash_table_pkg.sv
`include "hash_table_macros.svh"

package hash_table_pkg;

    typedef enum logic [1:0] {
        OP_NOP    = 2'b00,  // idle slot, answered ok
        OP_READ   = 2'b01,
        OP_WRITE  = 2'b10,
        OP_DELETE = 2'b11
    } ht_op_e;

    typedef enum logic [2:0] {
        ST_OK          = 3'd0,
        ST_NOT_FOUND   = 3'd1,  // read miss
        ST_NO_SPACE    = 3'd2,  // all candidate buckets taken
        ST_KEY_PRESENT = 3'd3,  // write of a stored key
        ST_NO_TARGET   = 3'd4   // delete miss
    } ht_status_e;

    typedef struct packed {
        ht_op_e                    op;
        logic [`HT_KEY_WIDTH-1:0]  key;
        logic [`HT_DATA_WIDTH-1:0] data;
    } ht_req_t;

    typedef struct packed {
        ht_status_e                status;
        logic [`HT_DATA_WIDTH-1:0] data;
    } ht_rsp_t;

    typedef struct packed {
        logic                      valid;
        logic [`HT_KEY_WIDTH-1:0]  key;
        logic [`HT_DATA_WIDTH-1:0] data;
    } ht_entry_t;

endpackage

//--- hdl/h3_hash.sv
`timescale 1ns/100ps

`include "hash_table_macros.svh"

module h3_hash #(
    parameter int TABLE_INDEX = 0
) (
    input  logic [`HT_KEY_WIDTH-1:0] key_i,
    output logic [`HT_ADR_WIDTH-1:0] adr_o
);

    localparam int Q_BITS = `HT_KEY_WIDTH * `HT_ADR_WIDTH;

    // rows of the selected table
    localparam logic [Q_BITS-1:0] Q_ROWS =
        (TABLE_INDEX == 0) ? `HT_Q_TABLE_0 :
        (TABLE_INDEX == 1) ? `HT_Q_TABLE_1 :
                             `HT_Q_TABLE_2;

    logic [`HT_KEY_WIDTH-1:0] masked [`HT_ADR_WIDTH];

    always_comb begin
        for (int b = 0; b < `HT_ADR_WIDTH; b++) begin
            masked[b] = key_i & Q_ROWS[b*`HT_KEY_WIDTH +: `HT_KEY_WIDTH];
        end
    end

    // each address bit is the parity of one masked key
    always_comb begin
        for (int b = 0; b < `HT_ADR_WIDTH; b++) begin
            adr_o[b] = ^masked[b];
        end
    end

endmodule

//--- hdl/bucket_ram.sv
`timescale 1ns/100ps

`include "hash_table_macros.svh"

module bucket_ram
    import hash_table_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic [`HT_ADR_WIDTH-1:0] adr_i,
    input  logic                     wr_en_i,
    input  ht_entry_t                wr_entry_i,
    output ht_entry_t                rd_entry_o
);

    localparam int DEPTH     = 1 << `HT_ADR_WIDTH;
    localparam int PAYLOAD_W = `HT_KEY_WIDTH + `HT_DATA_WIDTH;

    logic [PAYLOAD_W-1:0] mem [DEPTH];  // key and data
    logic [DEPTH-1:0]     valid_q;      // one flag per bucket
    logic [PAYLOAD_W-1:0] rd_payload_q;
    logic                 rd_valid_q;

    // block ram part, old contents on a same-address read
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[adr_i] <= {wr_entry_i.key, wr_entry_i.data};
        end
        rd_payload_q <= mem[adr_i];
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (wr_en_i) begin
                valid_q[adr_i] <= wr_entry_i.valid;
            end
            rd_valid_q <= valid_q[adr_i];
        end
    end

    assign rd_entry_o = {rd_valid_q, rd_payload_q};

endmodule

//--- hdl/table_controller.sv
`timescale 1ns/100ps

`include "hash_table_macros.svh"

module table_controller
    import hash_table_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  ht_req_t                             req_i,
    input  logic                                req_valid_i,
    output logic                                req_ready_o,
    output ht_rsp_t                             rsp_o,
    output logic                                rsp_valid_o,
    input  logic                                rsp_ready_i,
    output logic [`HT_KEY_WIDTH-1:0]            lookup_key_o,
    input  ht_entry_t [`HT_NUM_TABLES-1:0]      entries_i,
    output logic [`HT_NUM_TABLES-1:0]           wr_en_o,
    output ht_entry_t                           wr_entry_o
);

    localparam int NT = `HT_NUM_TABLES;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_DECIDE,
        S_RESPOND
    } state_e;

    state_e                    state_q;
    state_e                    state_d;
    ht_req_t                   req_q;
    ht_rsp_t                   rsp_q;
    ht_rsp_t                   rsp_d;
    logic                      req_take;
    logic [NT-1:0]             hit_vec;
    logic [NT-1:0]             free_vec;
    logic [NT-1:0]             hit_first;
    logic [NT-1:0]             free_first;
    logic [`HT_DATA_WIDTH-1:0] hit_data;
    logic [NT-1:0]             wr_sel;
    ht_entry_t                 wr_entry;

    assign req_take = req_valid_i && req_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (req_take) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                state_d = S_DECIDE;  // ram read in flight
            end
            S_DECIDE: begin
                state_d = S_RESPOND;
            end
            S_RESPOND: begin
                if (rsp_ready_i) begin
                    state_d = S_IDLE;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (req_take) begin
            req_q <= req_i;
        end
        if (state_q == S_DECIDE) begin
            rsp_q <= rsp_d;
        end
    end

    // match and free detection over all tables
    always_comb begin
        for (int t = 0; t < NT; t++) begin
            hit_vec[t]  = entries_i[t].valid && (entries_i[t].key == req_q.key);
            free_vec[t] = !entries_i[t].valid;
        end
    end

    assign hit_first  = hit_vec & (~hit_vec + NT'(1));    // lowest set bit
    assign free_first = free_vec & (~free_vec + NT'(1));

    always_comb begin
        hit_data = '0;
        for (int t = 0; t < NT; t++) begin
            if (hit_first[t]) begin
                hit_data = hit_data | entries_i[t].data;
            end
        end
    end

    always_comb begin
        rsp_d    = '{status: ST_OK, data: '0};
        wr_sel   = '0;
        wr_entry = '{valid: 1'b1, key: req_q.key, data: req_q.data};
        case (req_q.op)
            OP_READ: begin
                if (|hit_vec) begin
                    rsp_d.data = hit_data;
                end else begin
                    rsp_d.status = ST_NOT_FOUND;
                end
            end
            OP_WRITE: begin
                if (|hit_vec) begin
                    rsp_d.status = ST_KEY_PRESENT;
                end else if (|free_vec) begin
                    wr_sel = free_first;  // lowest free table
                end else begin
                    rsp_d.status = ST_NO_SPACE;
                end
            end
            OP_DELETE: begin
                if (|hit_vec) begin
                    wr_sel         = hit_first;
                    wr_entry.valid = 1'b0;
                    wr_entry.data  = hit_data;  // contents kept, flag dropped
                end else begin
                    rsp_d.status = ST_NO_TARGET;
                end
            end
            default: begin
                rsp_d.status = ST_OK;  // nop
            end
        endcase
    end

    assign wr_en_o      = (state_q == S_DECIDE) ? wr_sel : '0;
    assign wr_entry_o   = wr_entry;
    assign lookup_key_o = req_q.key;
    assign req_ready_o  = (state_q == S_IDLE);
    assign rsp_valid_o  = (state_q == S_RESPOND);
    assign rsp_o        = rsp_q;

endmodule

//--- hdl/hash_table.sv
`timescale 1ns/100ps

`include "hash_table_macros.svh"

module hash_table
    import hash_table_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  ht_req_t req_i,
    input  logic    req_valid_i,
    output logic    req_ready_o,
    output ht_rsp_t rsp_o,
    output logic    rsp_valid_o,
    input  logic    rsp_ready_i
);

    logic [`HT_KEY_WIDTH-1:0]       lookup_key;
    ht_entry_t [`HT_NUM_TABLES-1:0] entries;
    logic [`HT_NUM_TABLES-1:0]      wr_en;
    ht_entry_t                      wr_entry;

    table_controller i_table_controller (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .rsp_o        (rsp_o),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .lookup_key_o (lookup_key),
        .entries_i    (entries),
        .wr_en_o      (wr_en),
        .wr_entry_o   (wr_entry)
    );

    // one hash and one bucket memory per table
    for (genvar t = 0; t < `HT_NUM_TABLES; t++) begin : g_table
        logic [`HT_ADR_WIDTH-1:0] adr;  // read and write share it

        h3_hash #(
            .TABLE_INDEX (t)
        ) i_h3_hash (
            .key_i (lookup_key),
            .adr_o (adr)
        );

        bucket_ram i_bucket_ram (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .adr_i      (adr),
            .wr_en_i    (wr_en[t]),
            .wr_entry_i (wr_entry),
            .rd_entry_o (entries[t])
        );
    end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,  // ns, 20 ns clock
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;  // released away from the rising edge
    end

endmodule

//--- verif/hash_table_tb.sv
`timescale 1ns/100ps

`include "hash_table_macros.svh"

module hash_table_tb
    import hash_table_pkg::*;
();

    localparam int    NT            = `HT_NUM_TABLES;
    localparam int    BUCKETS       = 1 << `HT_ADR_WIDTH;
    localparam int    Q_BITS        = `HT_KEY_WIDTH * `HT_ADR_WIDTH;
    localparam int    OVERFLOW_TEST = 5;  // its write keys share one bucket everywhere
    localparam string VEC_FILE      = "verif/hash_table_vectors.txt";

    typedef struct {
        int                        test;
        logic [1:0]                op;
        logic [`HT_KEY_WIDTH-1:0]  key;
        logic [`HT_DATA_WIDTH-1:0] data;
        logic [2:0]                status;
        logic [`HT_DATA_WIDTH-1:0] exp_data;
    } vector_t;

    logic    clk;
    logic    rst_n;
    ht_req_t req_i;
    logic    req_valid_i;
    logic    req_ready_o;
    ht_rsp_t rsp_o;
    logic    rsp_valid_o;
    logic    rsp_ready_i;

    vector_t vecs[$];
    logic [31:0] rng_state   = 32'h7720_f15c;
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 50;  // raised once the vectors are loaded
    int cur_test    = 0;
    int test_errors = 0;
    int test_ops    = 0;
    int error_total = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    logic                      have_ref = 1'b0;
    logic [`HT_KEY_WIDTH-1:0]  ref_key;

    // reference model, one bucket array per table
    logic                      m_valid [NT][BUCKETS];
    logic [`HT_KEY_WIDTH-1:0]  m_key   [NT][BUCKETS];
    logic [`HT_DATA_WIDTH-1:0] m_data  [NT][BUCKETS];

    tb_clock_gen #(
        .HALF_PERIOD  (10),
        .RESET_CYCLES (10)
    ) i_tb_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    hash_table i_hash_table (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .rsp_o       (rsp_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // address bit b is the parity of the key under row b of the table's Q matrix
    function automatic logic [`HT_ADR_WIDTH-1:0] bucket_of(input int tbl,
                                                           input logic [`HT_KEY_WIDTH-1:0] key);
        logic [Q_BITS-1:0]        rows;
        logic [`HT_ADR_WIDTH-1:0] adr;
        case (tbl)
            0:       rows = `HT_Q_TABLE_0;
            1:       rows = `HT_Q_TABLE_1;
            default: rows = `HT_Q_TABLE_2;
        endcase
        for (int b = 0; b < `HT_ADR_WIDTH; b++) begin
            adr[b] = ^(key & rows[b*`HT_KEY_WIDTH +: `HT_KEY_WIDTH]);
        end
        return adr;
    endfunction

    function automatic logic [BUCKETS-1:0] dut_valid_flags(input int tbl);
        case (tbl)
            0:       return i_hash_table.g_table[0].i_bucket_ram.valid_q;
            1:       return i_hash_table.g_table[1].i_bucket_ram.valid_q;
            default: return i_hash_table.g_table[2].i_bucket_ram.valid_q;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            test_errors++;
            error_total++;
        end
    endtask

    task automatic load_vectors(output logic ok);
        int    fd;
        int    n;
        string line;
        vector_t v;
        fd = $fopen(VEC_FILE, "r");
        ok = 1'b0;
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %h %h %d %h", v.test, v.op, v.key, v.data,
                                v.status, v.exp_data);
                    if (n == 6) begin
                        vecs.push_back(v);
                    end
                end
            end
            $fclose(fd);
            ok = (vecs.size() > 0);
        end
    endtask

    task automatic model_apply(input ht_op_e op, input logic [`HT_KEY_WIDTH-1:0] key,
                               input logic [`HT_DATA_WIDTH-1:0] data, output ht_status_e st,
                               output logic [`HT_DATA_WIDTH-1:0] rd_data);
        int hit_tbl;
        int free_tbl;
        logic [`HT_ADR_WIDTH-1:0] adr [NT];
        hit_tbl  = -1;
        free_tbl = -1;
        for (int t = 0; t < NT; t++) begin
            adr[t] = bucket_of(t, key);
            if (hit_tbl < 0 && m_valid[t][adr[t]] && m_key[t][adr[t]] == key) begin
                hit_tbl = t;
            end
            if (free_tbl < 0 && !m_valid[t][adr[t]]) begin
                free_tbl = t;  // lowest free table wins
            end
        end
        st      = ST_OK;
        rd_data = '0;
        case (op)
            OP_READ: begin
                if (hit_tbl >= 0) rd_data = m_data[hit_tbl][adr[hit_tbl]];
                else st = ST_NOT_FOUND;
            end
            OP_WRITE: begin
                if (hit_tbl >= 0) begin
                    st = ST_KEY_PRESENT;
                end else if (free_tbl >= 0) begin
                    m_valid[free_tbl][adr[free_tbl]] = 1'b1;
                    m_key[free_tbl][adr[free_tbl]]   = key;
                    m_data[free_tbl][adr[free_tbl]]  = data;
                end else begin
                    st = ST_NO_SPACE;
                end
            end
            OP_DELETE: begin
                if (hit_tbl >= 0) m_valid[hit_tbl][adr[hit_tbl]] = 1'b0;
                else st = ST_NO_TARGET;
            end
            default: ;
        endcase
    endtask

    // one request through the handshake, entered and left on a falling edge
    task automatic run_op(input ht_req_t req, output ht_rsp_t rsp);
        int lat;
        int stall;
        int idle;
        req_i       = req;
        req_valid_i = 1'b1;
        while (!req_ready_o) @(negedge clk);
        @(negedge clk);  // taken on the rising edge just passed
        req_valid_i = 1'b0;
        req_i       = '0;
        lat         = 1;
        while (!rsp_valid_o && lat < 16) begin
            check_value("req_ready_o while busy", 64'(req_ready_o), 64'(1'b0));
            @(negedge clk);
            lat++;
        end
        check_value("rsp_valid_o latency", 64'(lat), 64'(3));
        rsp       = rsp_o;
        rng_state = lcg_step(rng_state);
        stall     = int'(rng_state[18:16]);
        for (int i = 0; i < stall; i++) begin
            @(negedge clk);
            check_value("rsp_o under back-pressure", 64'(rsp_o), 64'(rsp));
            check_value("rsp_valid_o under back-pressure", 64'(rsp_valid_o), 64'(1'b1));
            check_value("req_ready_o under back-pressure", 64'(req_ready_o), 64'(1'b0));
        end
        rsp_ready_i = 1'b1;
        @(negedge clk);
        rsp_ready_i = 1'b0;
        check_value("rsp_valid_o after handshake", 64'(rsp_valid_o), 64'(1'b0));
        check_value("req_ready_o after handshake", 64'(req_ready_o), 64'(1'b1));
        rng_state = lcg_step(rng_state);
        idle      = int'(rng_state[17:16]);
        repeat (idle) @(negedge clk);
    endtask

    task automatic run_vector(input vector_t v);
        ht_req_t                   req;
        ht_rsp_t                   rsp;
        ht_status_e                m_st;
        logic [`HT_DATA_WIDTH-1:0] m_rd;
        logic [BUCKETS-1:0]        flags;
        logic [`HT_ADR_WIDTH-1:0]  adr;
        req.op   = ht_op_e'(v.op);
        req.key  = v.key;
        req.data = v.data;
        model_apply(req.op, v.key, v.data, m_st, m_rd);
        check_value("vector status against model", 64'(v.status), 64'(m_st));
        check_value("vector data against model", 64'(v.exp_data), 64'(m_rd));
        if (v.test == OVERFLOW_TEST && req.op == OP_WRITE) begin
            if (!have_ref) begin
                ref_key  = v.key;
                have_ref = 1'b1;
            end else begin
                for (int t = 0; t < NT; t++) begin
                    check_value($sformatf("table %0d bucket of key 0x%0h", t, v.key),
                                64'(bucket_of(t, v.key)), 64'(bucket_of(t, ref_key)));
                end
            end
        end
        run_op(req, rsp);
        check_value("rsp_o.status", 64'(rsp.status), 64'(v.status));
        check_value("rsp_o.data", 64'(rsp.data), 64'(v.exp_data));
        // the model tells which table holds the key
        for (int t = 0; t < NT; t++) begin
            adr   = bucket_of(t, v.key);
            flags = dut_valid_flags(t);
            check_value($sformatf("table %0d valid flag 0x%0h", t, adr),
                        64'(flags[adr]), 64'(m_valid[t][adr]));
        end
        test_ops++;
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("test %0d passed, %0d operations", cur_test, test_ops);
        end else begin
            fail_count++;
            $display("test %0d failed, %0d mismatches in %0d operations", cur_test,
                     test_errors, test_ops);
        end
        test_errors = 0;
        test_ops    = 0;
    endtask

    initial begin
        logic loaded;
        req_i       = '0;
        req_valid_i = 1'b0;
        rsp_ready_i = 1'b0;
        for (int t = 0; t < NT; t++) begin
            for (int a = 0; a < BUCKETS; a++) begin
                m_valid[t][a] = 1'b0;
            end
        end
        load_vectors(loaded);
        if (loaded) begin
            cycle_limit = vecs.size() * 16 + 50;
            cur_test    = vecs[0].test;
            @(posedge rst_n);
            @(negedge clk);
            check_value("req_ready_o after reset", 64'(req_ready_o), 64'(1'b1));
            check_value("rsp_valid_o after reset", 64'(rsp_valid_o), 64'(1'b0));
            check_value("wr_en after reset", 64'(i_hash_table.wr_en), 64'(0));
            for (int t = 0; t < NT; t++) begin
                check_value($sformatf("table %0d valid flags after reset", t),
                            64'(dut_valid_flags(t)), 64'(0));
            end
            foreach (vecs[i]) begin
                if (vecs[i].test != cur_test) begin
                    close_test();
                    cur_test = vecs[i].test;
                end
                run_vector(vecs[i]);
            end
            close_test();
        end else begin
            $display("could not read any vectors from %s", VEC_FILE);
        end
        $display("tests passed %0d, tests failed %0d, mismatches %0d", pass_count,
                 fail_count, error_total);
        if (loaded && fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- hash_table.f
+incdir+hdl
hdl/hash_table_pkg.sv
hdl/h3_hash.sv
hdl/bucket_ram.sv
hdl/table_controller.sv
hdl/hash_table.sv
verif/tb_clock_gen.sv
verif/hash_table_tb.sv

//--- Makefile
# Verilator build and run for the hash table testbench

VERILATOR ?= verilator
TOP       ?= hash_table_tb
FLIST     ?= hash_table.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)
VECTORS := verif/hash_table_vectors.txt

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides pass or fail, not the exit code of the binary
run: $(BIN) $(VECTORS)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -F -x '** PASS **' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/hash_table_vectors.txt
# test op key data status exp_data, key and data in hex
# op 0 nop 1 read 2 write 3 delete, status 0 ok 1 not_found 2 no_space 3 key_present 4 no_target
1 1 0010 00000000 1 00000000
1 1 8000 00000000 1 00000000
1 0 0000 00000000 0 00000000
1 1 0000 00000000 1 00000000
1 3 0020 00000000 4 00000000
2 2 0004 11110004 0 00000000
2 2 0008 22220008 0 00000000
2 2 0010 33330010 0 00000000
2 2 0100 44440100 0 00000000
2 2 0400 55550400 0 00000000
2 2 1000 66661000 0 00000000
2 1 0004 00000000 0 11110004
2 1 0008 00000000 0 22220008
2 1 0010 00000000 0 33330010
2 1 0100 00000000 0 44440100
2 1 0400 00000000 0 55550400
2 1 1000 00000000 0 66661000
2 1 0800 00000000 1 00000000
3 2 0008 DEADBEEF 3 00000000
3 1 0008 00000000 0 22220008
3 2 1000 CAFEF00D 3 00000000
3 1 1000 00000000 0 66661000
4 3 0010 00000000 0 00000000
4 1 0010 00000000 1 00000000
4 3 0010 00000000 4 00000000
4 2 0010 77770010 0 00000000
4 1 0010 00000000 0 77770010
4 1 0004 00000000 0 11110004
5 2 0000 A0000000 0 00000000
5 2 8001 A1008001 0 00000000
5 2 4002 A2004002 0 00000000
5 2 C003 A300C003 2 00000000
5 1 0000 00000000 0 A0000000
5 1 8001 00000000 0 A1008001
5 1 4002 00000000 0 A2004002
5 1 C003 00000000 1 00000000
6 3 8001 00000000 0 00000000
6 2 C003 B300C003 0 00000000
6 1 C003 00000000 0 B300C003
6 0 1234 89ABCDEF 0 00000000
6 3 0100 00000000 0 00000000
6 1 0100 00000000 1 00000000
